//--- rtl/mem_pkg.sv
package mem_pkg;

    // Queue sizing
    localparam int LSQ_NUM_ENTRIES = 8;
    localparam int LSQ_PTR_W       = 3;
    localparam int LSQ_CNT_W       = LSQ_PTR_W + 1;   // Holds 0 to LSQ_NUM_ENTRIES

    // Bus sizing
    localparam int XLEN            = 32;
    localparam int TAG_W           = 4;
    localparam int MAX_INFLIGHT    = LSQ_NUM_ENTRIES;

    // Access size as decoded by the AGU
    localparam logic [1:0] SIZE_B  = 2'd0;
    localparam logic [1:0] SIZE_H  = 2'd1;
    localparam logic [1:0] SIZE_W  = 2'd2;

    typedef enum logic [2:0] {
        LB,     // Signed byte load
        LH,     // Signed half load
        LW,     // Word load
        LBU,    // Unsigned byte load
        LHU,    // Unsigned half load
        SB,     // Byte store
        SH,     // Half store
        SW      // Word store
    } mem_op_t;

    // One decoded instruction waiting in the queue
    typedef struct packed {
        mem_op_t               op;
        logic [XLEN-1:0]       base;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       store_data;
        logic [TAG_W-1:0]      tag;
    } lsq_entry_t;

    typedef struct packed {
        logic [XLEN-1:0]       addr;        // Always word aligned
        logic                  we;
        logic [3:0]            be;
        logic [XLEN-1:0]       wdata;
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0]       rdata;
        logic                  retry;       // Memory asks for a replay
    } mem_rsp_t;

    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic                  is_load;
        logic [XLEN-1:0]       data;
        logic                  misaligned;
    } mem_result_t;

    typedef struct packed {
        logic [XLEN-1:0]       addr;        // Full byte address
        logic                  misaligned;
        logic                  is_load;
        logic                  signed_load;
        logic [1:0]            size;
    } agu_out_t;

    // What the control remembers about an issued request until its response
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic                  is_load;
        logic                  signed_load;
        logic [1:0]            size;
        logic [1:0]            offset;
    } mem_rec_t;

endpackage

//--- rtl/lsq.sv
`timescale 1ns/1ps

module lsq (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  mem_pkg::lsq_entry_t instr_i,          // Entry to write at tail
    input  logic                write_i,          // Write instr_i this cycle
    input  logic                flush_i,          // Drop every entry
    input  logic                read_next_i,      // Entry at next was issued
    input  logic                reset_next_i,     // Rewind next to head for replay
    input  logic                advance_head_i,   // Oldest entry completed
    output mem_pkg::lsq_entry_t next_entry_o,     // Entry waiting at next
    output logic                full_o,
    output logic                empty_o           // Nothing left to issue
);
    import mem_pkg::*;

    logic [LSQ_PTR_W-1:0] tail;    // Next free slot
    logic [LSQ_PTR_W-1:0] next;    // Next entry to issue
    logic [LSQ_PTR_W-1:0] head;    // Oldest entry not yet completed

    logic [LSQ_CNT_W-1:0] num;           // Entries held
    logic [LSQ_CNT_W-1:0] num_to_issue;  // Entries between next and tail
    logic [LSQ_CNT_W-1:0] num_in_flight; // Entries between head and next

    logic write_en;
    logic read_en;
    logic advance_en;

    lsq_entry_t entries [LSQ_NUM_ENTRIES];

    assign write_en   = write_i & (num < LSQ_CNT_W'(LSQ_NUM_ENTRIES));
    assign read_en    = read_next_i & (num_to_issue != '0) & ~reset_next_i;
    // A misaligned entry is read and retired in the same cycle
    assign advance_en = advance_head_i & ((num_in_flight != '0) | read_en);

    always_ff @(posedge clk_i) begin
        if (write_en) begin
            entries[tail] <= instr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tail          <= '0;
            next          <= '0;
            head          <= '0;
            num           <= '0;
            num_to_issue  <= '0;
            num_in_flight <= '0;
        end else if (flush_i) begin
            tail          <= '0;
            next          <= '0;
            head          <= '0;
            num           <= '0;
            num_to_issue  <= '0;
            num_in_flight <= '0;
        end else if (reset_next_i) begin
            // Replay from the oldest unfinished entry
            next          <= head;
            tail          <= tail + LSQ_PTR_W'(write_en);
            num           <= num + LSQ_CNT_W'(write_en) - LSQ_CNT_W'(advance_en);
            num_to_issue  <= num_to_issue + LSQ_CNT_W'(write_en) + num_in_flight;
            num_in_flight <= '0;
        end else begin
            tail          <= tail + LSQ_PTR_W'(write_en);
            next          <= next + LSQ_PTR_W'(read_en);
            head          <= head + LSQ_PTR_W'(advance_en);
            num           <= num + LSQ_CNT_W'(write_en) - LSQ_CNT_W'(advance_en);
            num_to_issue  <= num_to_issue + LSQ_CNT_W'(write_en) - LSQ_CNT_W'(read_en);
            num_in_flight <= num_in_flight + LSQ_CNT_W'(read_en) - LSQ_CNT_W'(advance_en);
        end
    end

    // Shown ungated so the control can look before it reads
    assign next_entry_o = entries[next];

    assign empty_o = (num_to_issue == '0);
    // Also full during flush and reset so nothing is written then
    assign full_o  = (num == LSQ_CNT_W'(LSQ_NUM_ENTRIES)) | flush_i | ~rstn_i;

endmodule

//--- rtl/agu.sv
`timescale 1ns/1ps

module agu (
    input  mem_pkg::lsq_entry_t entry_i,
    output mem_pkg::agu_out_t   agu_o
);
    import mem_pkg::*;

    logic [XLEN-1:0] addr;

    assign addr = entry_i.base + entry_i.imm;    // Effective byte address

    always_comb begin
        agu_o.addr        = addr;
        agu_o.is_load     = 1'b1;
        agu_o.signed_load = 1'b0;
        agu_o.size        = SIZE_W;
        case (entry_i.op)
            LB: begin
                agu_o.size        = SIZE_B;
                agu_o.signed_load = 1'b1;
            end
            LH: begin
                agu_o.size        = SIZE_H;
                agu_o.signed_load = 1'b1;
            end
            LBU: agu_o.size = SIZE_B;
            LHU: agu_o.size = SIZE_H;
            SB: begin
                agu_o.size    = SIZE_B;
                agu_o.is_load = 1'b0;
            end
            SH: begin
                agu_o.size    = SIZE_H;
                agu_o.is_load = 1'b0;
            end
            SW: agu_o.is_load = 1'b0;
            default: ;                           // LW keeps the word defaults
        endcase
        // Halves need an even address, words a multiple of four
        agu_o.misaligned = ((agu_o.size == SIZE_H) & addr[0]) |
                           ((agu_o.size == SIZE_W) & (addr[1:0] != 2'b00));
    end

endmodule

//--- rtl/store_fmt.sv
`timescale 1ns/1ps

module store_fmt (
    input  mem_pkg::lsq_entry_t entry_i,
    input  mem_pkg::agu_out_t   agu_i,
    output mem_pkg::mem_req_t   req_o
);
    import mem_pkg::*;

    logic [3:0]      be_base;     // Mask for an access at lane 0
    logic [XLEN-1:0] wdata_rep;

    always_comb begin
        case (agu_i.size)
            SIZE_B: begin
                be_base   = 4'b0001;
                wdata_rep = {4{entry_i.store_data[7:0]}};
            end
            SIZE_H: begin
                be_base   = 4'b0011;
                wdata_rep = {2{entry_i.store_data[15:0]}};
            end
            default: begin
                be_base   = 4'b1111;
                wdata_rep = entry_i.store_data;
            end
        endcase
    end

    assign req_o.addr  = {agu_i.addr[XLEN-1:2], 2'b00};
    assign req_o.we    = ~agu_i.is_load;
    // Loads fetch the whole word, load_align picks the bytes later
    assign req_o.be    = agu_i.is_load ? 4'b1111 : (be_base << agu_i.addr[1:0]);
    assign req_o.wdata = wdata_rep;                // Byte lanes filled by replication

endmodule

//--- rtl/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  logic [mem_pkg::XLEN-1:0] rdata_i,   // Raw response word
    input  logic [1:0]               offset_i,  // Byte address bits 1:0
    input  logic [1:0]               size_i,
    input  logic                     signed_i,
    output logic [mem_pkg::XLEN-1:0] data_o
);
    import mem_pkg::*;

    logic [XLEN-1:0] shifted;
    logic            sign_bit;

    // Bring the addressed byte down to lane 0
    assign shifted = rdata_i >> {offset_i, 3'b000};

    always_comb begin
        case (size_i)
            SIZE_B:  sign_bit = signed_i & shifted[7];
            SIZE_H:  sign_bit = signed_i & shifted[15];
            default: sign_bit = 1'b0;
        endcase
    end

    always_comb begin
        case (size_i)
            SIZE_B: begin
                data_o = {{(XLEN-8){sign_bit}}, shifted[7:0]};
            end
            SIZE_H: begin
                data_o = {{(XLEN-16){sign_bit}}, shifted[15:0]};
            end
            default: begin
                data_o = shifted;        // Word is aligned, offset is zero
            end
        endcase
    end

endmodule

//--- rtl/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       flush_i,
    input  logic                       empty_i,          // Nothing waiting at next
    input  mem_pkg::lsq_entry_t        entry_i,          // Entry at next
    input  mem_pkg::agu_out_t          agu_i,            // Its decoded access
    output logic                       read_next_o,
    output logic                       reset_next_o,
    output logic                       advance_head_o,
    output logic                       mem_req_valid_o,
    input  logic                       mem_req_ready_i,
    input  logic                       mem_rsp_valid_i,
    input  logic                       mem_rsp_retry_i,
    output logic                       mem_rsp_ready_o,
    output logic                       res_valid_o,
    input  logic                       res_ready_i,
    output logic [1:0]                 rec_offset_o,
    output logic [1:0]                 rec_size_o,
    output logic                       rec_signed_o,
    output logic [mem_pkg::TAG_W-1:0]  rec_tag_o,
    output logic                       rec_is_load_o,
    output logic                       res_misaligned_o
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_ISSUE,          // Normal operation
        ST_DRAIN_RETRY,    // Eat responses, then replay from head
        ST_DRAIN_FLUSH     // Eat responses of flushed requests
    } ctrl_state_t;

    ctrl_state_t          state_q, state_d;
    logic [LSQ_CNT_W-1:0] inflight_q;    // Doubles as the drop count while flushing
    logic                 hold_q;        // Request shown but not yet taken
    logic [LSQ_PTR_W-1:0] rec_wptr_q, rec_rptr_q;
    mem_rec_t             rec_q [LSQ_NUM_ENTRIES];
    mem_rec_t             rec_head;
    logic                 busy, can_issue, mis_ok, rsp_result, req_fire, rsp_fire;

    assign busy      = (inflight_q != '0);
    assign can_issue = ~empty_i & ~agu_i.misaligned & (inflight_q < LSQ_CNT_W'(MAX_INFLIGHT));
    // Misaligned entries retire only once everything older has answered
    assign mis_ok    = (state_q == ST_ISSUE) & ~empty_i & agu_i.misaligned & ~busy & ~flush_i;

    // A shown request stays up through a retry drain until memory takes it
    assign mem_req_valid_o = ~flush_i & (((state_q == ST_ISSUE) & can_issue) |
                                         ((state_q == ST_DRAIN_RETRY) & hold_q));
    assign req_fire        = mem_req_valid_o & mem_req_ready_i;

    assign rsp_result      = (state_q == ST_ISSUE) & busy & mem_rsp_valid_i &
                             ~mem_rsp_retry_i & ~flush_i;
    assign mem_rsp_ready_o = busy & (flush_i | (state_q != ST_ISSUE) |
                                     mem_rsp_retry_i | res_ready_i);
    assign rsp_fire        = mem_rsp_valid_i & mem_rsp_ready_o;

    assign res_valid_o     = rsp_result | mis_ok;
    assign read_next_o     = req_fire | (mis_ok & res_ready_i);
    assign advance_head_o  = res_ready_i & (rsp_result | mis_ok);
    assign reset_next_o    = (state_q == ST_DRAIN_RETRY) & ~busy & ~hold_q & ~flush_i;

    always_comb begin
        state_d = state_q;
        if (flush_i) begin
            state_d = ST_DRAIN_FLUSH;
        end else begin
            case (state_q)
                ST_ISSUE:       if (rsp_fire & mem_rsp_retry_i) state_d = ST_DRAIN_RETRY;
                ST_DRAIN_RETRY: if (reset_next_o) state_d = ST_ISSUE;
                default:        if (!busy) state_d = ST_ISSUE;    // Drop count reached zero
            endcase
        end
    end

    // Record of each issued request, popped as its response returns
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            rec_q[rec_wptr_q] <= '{tag:         entry_i.tag,
                                   is_load:     agu_i.is_load,
                                   signed_load: agu_i.signed_load,
                                   size:        agu_i.size,
                                   offset:      agu_i.addr[1:0]};
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q    <= ST_ISSUE;
            inflight_q <= '0;
            hold_q     <= 1'b0;
            rec_wptr_q <= '0;
            rec_rptr_q <= '0;
        end else begin
            state_q    <= state_d;
            inflight_q <= inflight_q + LSQ_CNT_W'(req_fire) - LSQ_CNT_W'(rsp_fire);
            hold_q     <= mem_req_valid_o & ~mem_req_ready_i;
            rec_wptr_q <= rec_wptr_q + LSQ_PTR_W'(req_fire);
            rec_rptr_q <= rec_rptr_q + LSQ_PTR_W'(rsp_fire);
        end
    end

    assign rec_head         = rec_q[rec_rptr_q];
    assign rec_offset_o     = rec_head.offset;
    assign rec_size_o       = rec_head.size;
    assign rec_signed_o     = rec_head.signed_load;
    // A misaligned result takes its identity from the queue entry itself
    assign rec_tag_o        = mis_ok ? entry_i.tag : rec_head.tag;
    assign rec_is_load_o    = mis_ok ? agu_i.is_load : rec_head.is_load;
    assign res_misaligned_o = mis_ok;

endmodule

//--- rtl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 flush_i,
    // Instructions from the core
    input  logic                 instr_valid_i,
    output logic                 instr_ready_o,
    input  mem_pkg::lsq_entry_t  instr_i,
    // Memory request port
    output logic                 mem_req_valid_o,
    input  logic                 mem_req_ready_i,
    output mem_pkg::mem_req_t    mem_req_o,
    // Memory response port, in request order
    input  logic                 mem_rsp_valid_i,
    output logic                 mem_rsp_ready_o,
    input  mem_pkg::mem_rsp_t    mem_rsp_i,
    // Results back to the core
    output logic                 res_valid_o,
    input  logic                 res_ready_i,
    output mem_pkg::mem_result_t res_o
);
    import mem_pkg::*;

    lsq_entry_t       next_entry;
    agu_out_t         next_agu;
    logic             lsq_full, lsq_empty;
    logic             read_next, reset_next, advance_head;
    logic [1:0]       rec_offset, rec_size;
    logic             rec_signed, rec_is_load, res_misaligned;
    logic [TAG_W-1:0] rec_tag;
    logic [XLEN-1:0]  load_data;

    assign instr_ready_o = ~lsq_full;

    lsq u_lsq (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_i        (instr_i),
        .write_i        (instr_valid_i & instr_ready_o),
        .flush_i        (flush_i),
        .read_next_i    (read_next),
        .reset_next_i   (reset_next),
        .advance_head_i (advance_head),
        .next_entry_o   (next_entry),
        .full_o         (lsq_full),
        .empty_o        (lsq_empty)
    );

    agu u_agu (
        .entry_i (next_entry),
        .agu_o   (next_agu)
    );

    store_fmt u_store_fmt (
        .entry_i (next_entry),
        .agu_i   (next_agu),
        .req_o   (mem_req_o)
    );

    mem_ctrl u_mem_ctrl (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .flush_i          (flush_i),
        .empty_i          (lsq_empty),
        .entry_i          (next_entry),
        .agu_i            (next_agu),
        .read_next_o      (read_next),
        .reset_next_o     (reset_next),
        .advance_head_o   (advance_head),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_retry_i  (mem_rsp_i.retry),
        .mem_rsp_ready_o  (mem_rsp_ready_o),
        .res_valid_o      (res_valid_o),
        .res_ready_i      (res_ready_i),
        .rec_offset_o     (rec_offset),
        .rec_size_o       (rec_size),
        .rec_signed_o     (rec_signed),
        .rec_tag_o        (rec_tag),
        .rec_is_load_o    (rec_is_load),
        .res_misaligned_o (res_misaligned)
    );

    load_align u_load_align (
        .rdata_i  (mem_rsp_i.rdata),
        .offset_i (rec_offset),
        .size_i   (rec_size),
        .signed_i (rec_signed),
        .data_o   (load_data)
    );

    // Misaligned results carry no data, stores return the aligned word unused
    assign res_o = '{tag:        rec_tag,
                     is_load:    rec_is_load,
                     data:       res_misaligned ? '0 : load_data,
                     misaligned: res_misaligned};

endmodule

//--- bench/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
    import mem_pkg::*;

    localparam int N_INSTR   = 10 + 7 + 16 + 12 + 6 + 10;   // Instructions over all tests
    localparam int MAX_CYCLE = N_INSTR * 12 + 200;

    logic        clk_i = 1'b0, rstn_i = 1'b0, flush_i = 1'b0;
    logic        instr_valid_i = 1'b0, mem_req_ready_i = 1'b0;
    logic        mem_rsp_valid_i = 1'b0, res_ready_i = 1'b0;
    lsq_entry_t  instr_i = '0;
    mem_rsp_t    mem_rsp_i = '0;
    logic        instr_ready_o, mem_req_valid_o, mem_rsp_ready_o, res_valid_o;
    mem_req_t    mem_req_o;
    mem_result_t res_o;

    logic [31:0] mem_img [256];         // Memory model contents
    logic [31:0] ref_img [256];         // Scoreboard image, updated in program order
    mem_rsp_t    pend_rsp [$];          // Answers waiting, in request order
    int          pend_due [$];
    mem_result_t exp_q [$];             // Expected results in tag order
    mem_req_t    req_q [$];             // Expected requests when no replay happens
    logic [15:0] flushed = '0;
    bit          retry_en, req_check, req_hold, res_hold, flush_test;
    bit          replay_wait, retry_seen;   // Retry state of the memory model
    bit          hold_prev;
    mem_req_t    req_prev;
    int          errors, checks, cyc;
    integer      seed = 32'h1f81_f81a;

    mem_stage u_mem_stage (.*);

    always #2 clk_i = ~clk_i;

    function automatic logic [1:0] op_size(mem_op_t op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            default:     return 2'd2;
        endcase
    endfunction

    // Byte selection and extension of a load from its word
    function automatic logic [31:0] pick(logic [31:0] word, logic [1:0] off, mem_op_t op);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (op)
            LB:      return {{24{sh[7]}}, sh[7:0]};
            LBU:     return {24'h0, sh[7:0]};
            LH:      return {{16{sh[15]}}, sh[15:0]};
            LHU:     return {16'h0, sh[15:0]};
            default: return word;
        endcase
    endfunction

    task automatic wrong_value(string name, logic [127:0] got, logic [127:0] exp);
        $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic fault(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // Queue one instruction and record what it must produce
    task automatic send(mem_op_t op, logic [31:0] addr, logic [31:0] sd, logic [3:0] tag);
        logic [31:0] imm, wd;
        logic [3:0]  be;
        logic [1:0]  sz;
        logic        st, mis;
        mem_result_t r;
        mem_req_t    q;
        imm = {24'h0, 8'($random(seed))};                 // Random split of the address
        sz  = op_size(op);
        st  = (op == SB) || (op == SH) || (op == SW);
        mis = ((sz == 2'd1) && addr[0]) || ((sz == 2'd2) && (addr[1:0] != 2'b00));
        be  = (sz == 2'd0) ? 4'b0001 << addr[1:0] : (sz == 2'd1) ? 4'b0011 << addr[1:0] : 4'hf;
        wd  = (sz == 2'd0) ? {4{sd[7:0]}} : (sz == 2'd1) ? {2{sd[15:0]}} : sd;
        r   = '{tag: tag, is_load: !st, misaligned: mis,
                data: st ? 32'h0 : pick(ref_img[addr[9:2]], addr[1:0], op)};
        if (!mis) begin
            q = '{addr: {addr[31:2], 2'b00}, we: st, be: st ? be : 4'hf, wdata: wd};
            req_q.push_back(q);
            for (int b = 0; b < 4; b++)
                if (st && be[b]) ref_img[addr[9:2]][8*b +: 8] = wd[8*b +: 8];
        end
        exp_q.push_back(r);
        @(negedge clk_i);
        instr_valid_i = 1'b1;
        instr_i = '{op: op, base: addr - imm, imm: imm, store_data: sd, tag: tag};
        @(posedge clk_i);
        while (!instr_ready_o) @(posedge clk_i);
        @(negedge clk_i);
        instr_valid_i = 1'b0;
    endtask

    task automatic wait_done();
        while (exp_q.size() != 0 || pend_rsp.size() != 0 || mem_req_valid_o) @(posedge clk_i);
        @(negedge clk_i);
        req_q.delete();
    endtask

    task automatic report(int n, string name);
        $display("test %0d %s: done, %0d errors so far", n, name, errors);
    endtask

    // Memory model and checks, all sampled at the rising edge
    always @(posedge clk_i) begin : model_blk
        logic        rt;
        logic [7:0]  w;
        mem_result_t e;
        if (rstn_i) begin
            if (mem_req_valid_o && mem_req_ready_i) begin
                // After a retry the memory performs nothing until the replay begins
                rt = retry_en && (replay_wait || !retry_seen || (($random(seed) & 7) == 0));
                if (rt) begin
                    replay_wait = 1'b1;
                    retry_seen  = 1'b1;
                end
                w  = mem_req_o.addr[9:2];
                if (req_check) begin
                    if (req_q.size() == 0) fault("request issued that no instruction asked for");
                    else assert (mem_req_o == req_q[0])
                        else wrong_value("mem_req_o", mem_req_o, req_q[0]);
                    if (req_q.size() != 0) void'(req_q.pop_front());
                end
                for (int b = 0; b < 4; b++)
                    if (!rt && mem_req_o.we && mem_req_o.be[b])
                        mem_img[w][8*b +: 8] = mem_req_o.wdata[8*b +: 8];
                pend_rsp.push_back('{rdata: mem_img[w], retry: rt});
                pend_due.push_back(cyc + 1 + ($random(seed) & 3));   // 1 to 4 cycles later
            end
            if (mem_rsp_valid_i && mem_rsp_ready_o) begin
                void'(pend_rsp.pop_front());
                void'(pend_due.pop_front());
            end
            // Replay starts once every refused request has been answered
            if (replay_wait && pend_rsp.size() == 0 && !mem_req_valid_o) replay_wait = 1'b0;
            if (res_valid_o && res_ready_i) begin
                checks++;
                if (flush_test && flushed[res_o.tag]) begin
                    fault($sformatf("result returned for flushed tag %0d", res_o.tag));
                end else if (exp_q.size() == 0) begin
                    fault($sformatf("result with tag %0d that nothing expected", res_o.tag));
                end else begin
                    e = exp_q.pop_front();
                    assert (res_o.tag == e.tag) else wrong_value("res_o.tag", res_o.tag, e.tag);
                    assert (res_o.misaligned == e.misaligned)
                        else wrong_value("res_o.misaligned", res_o.misaligned, e.misaligned);
                    assert (res_o.is_load == e.is_load)
                        else wrong_value("res_o.is_load", res_o.is_load, e.is_load);
                    assert (!e.is_load || e.misaligned || res_o.data == e.data)
                        else wrong_value("res_o.data", res_o.data, e.data);
                end
            end
            // A waiting request must not change
            if (hold_prev && !flush_i)
                assert (mem_req_valid_o && mem_req_o == req_prev)
                    else fault("mem_req_o changed while waiting for mem_req_ready_i");
            if (!retry_en && !flush_test && !res_ready_i)
                assert (!mem_rsp_ready_o) else wrong_value("mem_rsp_ready_o", 1, 0);
            hold_prev = mem_req_valid_o && !mem_req_ready_i && !flush_i;
            req_prev  = mem_req_o;
        end
    end

    // Memory side inputs change on the falling edge
    always @(negedge clk_i) begin
        if (rstn_i) begin
            mem_req_ready_i = !req_hold && (($random(seed) & 3) != 0);
            res_ready_i     = !res_hold && (($random(seed) & 3) != 0);
            mem_rsp_valid_i = (pend_rsp.size() != 0) && (pend_due[0] <= cyc);
            mem_rsp_i       = mem_rsp_valid_i ? pend_rsp[0] : '0;
        end
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc > MAX_CYCLE) begin
            $display("Timeout after %0d cycles, the run did not finish", cyc);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem_img[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i) + 8'h81};
            ref_img[i] = mem_img[i];
        end
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        req_check = 1;
        send(LB, 32'h41, 0, 0);  send(LB, 32'h43, 0, 1);  send(LH, 32'h46, 0, 2);
        send(LW, 32'h48, 0, 3);  send(LBU, 32'h4d, 0, 4); send(LHU, 32'h52, 0, 5);
        send(LB, 32'h80, 0, 6);  send(LBU, 32'h283, 0, 7); send(LH, 32'h28a, 0, 8);
        send(LHU, 32'h28e, 0, 9);
        wait_done();
        report(1, "load widths");

        send(SB, 32'h101, 32'h0000_00a7, 0);
        send(SH, 32'h106, 32'h1234_8765, 1);
        send(SW, 32'h108, 32'hdead_beef, 2);
        send(SB, 32'h10b, 32'h0000_005c, 3);
        send(LW, 32'h100, 0, 4); send(LW, 32'h104, 0, 5); send(LW, 32'h108, 0, 6);
        wait_done();
        report(2, "store formatting");

        req_check = 0;
        retry_en  = 1;
        for (int i = 0; i < 16; i++) begin
            if (i % 3 == 0) send(SW, 32'h200 + 4 * (i % 4), $random(seed), 4'(i));
            else if (i % 3 == 1) send(LW, 32'h200 + 4 * (i % 4), 0, 4'(i));
            else send(LBU, 32'h200 + 4 * (i % 4) + (i % 4), 0, 4'(i));
        end
        wait_done();
        retry_en = 0;
        report(3, "retry replay");

        req_check = 1;
        res_hold  = 1;                             // Responses pile up at the port
        for (int i = 0; i < 4; i++) send(LW, 32'h300 + 4 * i, 0, 4'(i));
        repeat (12) @(negedge clk_i);
        res_hold = 0;
        wait_done();
        req_hold = 1;                              // Nothing issues, queue fills
        for (int i = 4; i < 12; i++) send(LW, 32'h300 + 4 * i, 0, 4'(i));
        @(negedge clk_i);
        assert (!instr_ready_o) else fault("instr_ready_o stayed high with eight entries queued");
        repeat (4) @(negedge clk_i);
        req_hold = 0;
        wait_done();
        report(4, "back-pressure");

        send(LW, 32'h40, 0, 0);  send(LH, 32'h45, 0, 1);  send(SW, 32'h42, 32'h5555_aaaa, 2);
        send(LW, 32'h44, 0, 3);  send(SH, 32'h47, 32'h0000_1111, 4);
        send(LHU, 32'h46, 0, 5);
        wait_done();
        report(5, "misalignment");

        req_check  = 0;
        flush_test = 1;
        for (int i = 0; i < 6; i++) send(LW, 32'h20 + 4 * i, 0, 4'(i));
        @(negedge clk_i);
        foreach (exp_q[k]) flushed[exp_q[k].tag] = 1'b1;   // Still pending, so dropped
        exp_q.delete();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        for (int i = 8; i < 12; i++) send(LW, 32'h60 + 4 * i, 0, 4'(i));
        wait_done();
        flush_test = 0;
        report(6, "flush");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
rtl/mem_pkg.sv
rtl/lsq.sv
rtl/agu.sv
rtl/store_fmt.sv
rtl/load_align.sv
rtl/mem_ctrl.sv
rtl/mem_stage.sv
bench/tb_mem_stage.sv
